/* hw/tagger_link_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tagger link management package
// Address map, bus widths, opcodes and FSM states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package tagger_link_pkg;

    // Wishbone word address and data widths
    localparam int ADDR_W = 24;
    localparam int DATA_W = 32;

    // Slave pages in address bits 23..8
    localparam logic [15:0] PAGE_ACK  = 16'h8000;
    localparam logic [15:0] PAGE_I2C  = 16'h8001;
    localparam logic [15:0] PAGE_LINK = 16'h8015;

    typedef enum logic {OP_READ, OP_WRITE} host_op_e;

    typedef enum logic [1:0] {BR_IDLE, BR_BUS, BR_RESP} bridge_state_e;

    typedef enum logic [2:0] {
        IDLE, START, BIT_LOW, BIT_HIGH, ACK_LOW, ACK_HIGH, STOP, DONE
    } i2c_state_e;

    // I2C master register offsets
    localparam logic [7:0] I2C_PRESCALE = 8'd0;
    localparam logic [7:0] I2C_TXDATA   = 8'd1;
    localparam logic [7:0] I2C_CMD      = 8'd2;
    localparam logic [7:0] I2C_STATUS   = 8'd3;

    // Bits of the I2C command word
    localparam int CMD_START = 0;
    localparam int CMD_STOP  = 1;
    localparam int CMD_READ  = 2;
    localparam int CMD_NACK  = 3;

    // Link block register offsets
    localparam logic [7:0] LINK_ID      = 8'd0;
    localparam logic [7:0] LINK_SCRATCH = 8'd1;
    localparam logic [7:0] LINK_CONTROL = 8'd2;
    localparam logic [7:0] LINK_STATUS  = 8'd3;

    localparam logic [31:0] LINK_ID_VALUE = 32'h7A67_0A10;

endpackage

`default_nettype wire

/* hw/wb_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic bus
// One master side, one selected slave side
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

interface wb_if;

    logic [tagger_link_pkg::ADDR_W-1:0] adr;
    logic [tagger_link_pkg::DATA_W-1:0] dat_w;
    logic [tagger_link_pkg::DATA_W-1:0] dat_r;
    logic                               we;
    logic                               cyc;
    logic                               stb;
    logic                               ack;
    // Only the decoder raises err
    logic                               err;

    modport master (
        output adr, dat_w, we, cyc, stb,
        input  ack, err, dat_r
    );

    // Decoder sees the master and answers it
    modport decoder (
        input  adr, dat_w, we, cyc, stb,
        output ack, err, dat_r
    );

    // Single slave view behind the decoder
    modport slave (
        input  adr, dat_w, we, cyc, stb,
        output ack, dat_r
    );

endinterface

`default_nettype wire

/* hw/host_wb_bridge.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host command to Wishbone bridge
// One bus cycle per command, with ack timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module host_wb_bridge #(
    parameter int ACK_TIMEOUT = 64
) (
    input  wire                                okClk,
    input  wire                                rst_n_i,
    input  wire                                cmd_valid_i,
    output logic                               cmd_ready_o,
    input  tagger_link_pkg::host_op_e          cmd_op_i,
    input  wire [tagger_link_pkg::ADDR_W-1:0]  cmd_addr_i,
    input  wire [tagger_link_pkg::DATA_W-1:0]  cmd_data_i,
    output logic                               rsp_valid_o,
    input  wire                                rsp_ready_i,
    output logic [tagger_link_pkg::DATA_W-1:0] rsp_data_o,
    output logic                               rsp_err_o,
    wb_if.master                               wb
);

    localparam int TO_W = $clog2(ACK_TIMEOUT + 1);

    tagger_link_pkg::bridge_state_e state_q;

    logic [tagger_link_pkg::ADDR_W-1:0] adr_q;
    logic [tagger_link_pkg::DATA_W-1:0] dat_q;
    logic                               we_q;
    logic [TO_W-1:0]                    to_cnt_q;
    logic                               timeout;

    // Bus cycle is live for the whole BR_BUS state
    assign wb.adr   = adr_q;
    assign wb.dat_w = dat_q;
    assign wb.we    = we_q;
    assign wb.cyc   = (state_q == tagger_link_pkg::BR_BUS);
    assign wb.stb   = (state_q == tagger_link_pkg::BR_BUS);

    assign cmd_ready_o = (state_q == tagger_link_pkg::BR_IDLE);
    assign rsp_valid_o = (state_q == tagger_link_pkg::BR_RESP);
    assign timeout     = (to_cnt_q == TO_W'(ACK_TIMEOUT - 1));

    // Command payload
    always_ff @(posedge okClk) begin
        if (cmd_valid_i && cmd_ready_o) begin
            adr_q <= cmd_addr_i;
            dat_q <= cmd_data_i;
            we_q  <= (cmd_op_i == tagger_link_pkg::OP_WRITE);
        end
    end

    always_ff @(posedge okClk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= tagger_link_pkg::BR_IDLE;
            to_cnt_q   <= '0;
            rsp_data_o <= '0;
            rsp_err_o  <= 1'b0;
        end else begin
            case (state_q)
                tagger_link_pkg::BR_IDLE: begin
                    to_cnt_q <= '0;
                    if (cmd_valid_i) begin
                        state_q <= tagger_link_pkg::BR_BUS;
                    end
                end
                tagger_link_pkg::BR_BUS: begin
                    to_cnt_q <= to_cnt_q + 1'b1;
                    if (wb.ack) begin
                        // Writes answer with zero data
                        rsp_data_o <= we_q ? '0 : wb.dat_r;
                        rsp_err_o  <= 1'b0;
                        state_q    <= tagger_link_pkg::BR_RESP;
                    end else if (wb.err || timeout) begin
                        rsp_data_o <= '0;
                        rsp_err_o  <= 1'b1;
                        state_q    <= tagger_link_pkg::BR_RESP;
                    end
                end
                tagger_link_pkg::BR_RESP: begin
                    // Hold response until the host takes it
                    if (rsp_ready_i) begin
                        state_q <= tagger_link_pkg::BR_IDLE;
                    end
                end
                default: begin
                    state_q <= tagger_link_pkg::BR_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/wb_addr_decoder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone address decoder
// Page select, ack sink and unmapped error
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module wb_addr_decoder (
    input  wire    okClk,
    input  wire    rst_n_i,
    wb_if.decoder  m,
    wb_if.master   s_i2c,
    wb_if.master   s_link
);

    logic [15:0] page;
    logic        sel_ack;
    logic        sel_i2c;
    logic        sel_link;
    logic        sel_none;
    logic        sink_ack_q;
    logic        err_q;

    assign page     = m.adr[23:8];
    assign sel_ack  = (page == tagger_link_pkg::PAGE_ACK);
    assign sel_i2c  = (page == tagger_link_pkg::PAGE_I2C);
    assign sel_link = (page == tagger_link_pkg::PAGE_LINK);
    assign sel_none = !(sel_ack || sel_i2c || sel_link);

    // Shared request lines, strobes per slave
    assign s_i2c.adr    = m.adr;
    assign s_i2c.dat_w  = m.dat_w;
    assign s_i2c.we     = m.we;
    assign s_i2c.cyc    = m.cyc && sel_i2c;
    assign s_i2c.stb    = m.stb && sel_i2c;
    assign s_link.adr   = m.adr;
    assign s_link.dat_w = m.dat_w;
    assign s_link.we    = m.we;
    assign s_link.cyc   = m.cyc && sel_link;
    assign s_link.stb   = m.stb && sel_link;

    // Local sink acks and error for unmapped pages, one pulse per strobe
    always_ff @(posedge okClk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sink_ack_q <= 1'b0;
            err_q      <= 1'b0;
        end else begin
            sink_ack_q <= m.cyc && m.stb && sel_ack && !sink_ack_q;
            err_q      <= m.cyc && m.stb && sel_none && !err_q;
        end
    end

    assign m.ack = sink_ack_q || s_i2c.ack || s_link.ack;
    assign m.err = err_q;

    // Sink and unmapped pages read as zero
    always_comb begin
        if (sel_i2c) begin
            m.dat_r = s_i2c.dat_r;
        end else if (sel_link) begin
            m.dat_r = s_link.dat_r;
        end else begin
            m.dat_r = '0;
        end
    end

endmodule

`default_nettype wire

/* hw/i2c_byte_master.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I2C byte master for the PLL
// One byte per command, optional start and stop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module i2c_byte_master #(
    parameter int PRESCALE_RESET = 4
) (
    input  wire  okClk,
    input  wire  rst_n_i,
    wb_if.slave  wb,
    output logic scl_o,
    output logic scl_oen_o,
    input  wire  scl_i,
    output logic sda_o,
    output logic sda_oen_o,
    input  wire  sda_i
);

    tagger_link_pkg::i2c_state_e state_q;

    logic [15:0] prescale_q;
    logic [15:0] div_q;
    logic [7:0]  tx_q;
    logic [7:0]  sh_q;
    logic [7:0]  rx_q;
    logic [2:0]  bit_q;
    logic [1:0]  step_q;
    logic        ack_q;
    logic        rx_nack_q;
    logic        stop_q;
    logic        rd_q;
    logic        nack_q;
    logic        scl_q;
    logic        sda_q;
    logic        busy;
    logic        wr;
    logic        go;
    logic        stretch;
    logic        tick;

    assign busy    = (state_q != tagger_link_pkg::IDLE);
    assign wr      = wb.cyc && wb.stb && wb.we && !ack_q;
    assign go      = wr && (wb.adr[7:0] == tagger_link_pkg::I2C_CMD) && !busy;
    // Released SCL held low by the target stalls the sequencer
    assign stretch = scl_q && !scl_i;
    assign tick    = (div_q == prescale_q) && !stretch;

    // Pads only ever pull low
    assign scl_o     = 1'b0;
    assign sda_o     = 1'b0;
    assign scl_oen_o = scl_q;
    assign sda_oen_o = sda_q;
    assign wb.ack    = ack_q;

    always_comb begin
        case (wb.adr[7:0])
            tagger_link_pkg::I2C_PRESCALE: wb.dat_r = {16'b0, prescale_q};
            tagger_link_pkg::I2C_TXDATA:   wb.dat_r = {24'b0, tx_q};
            tagger_link_pkg::I2C_STATUS:   wb.dat_r = {16'b0, rx_q, 6'b0, rx_nack_q, busy};
            default:                       wb.dat_r = '0;
        endcase
    end

    // Data byte, command flags and shifter
    always_ff @(posedge okClk) begin
        if (wr && wb.adr[7:0] == tagger_link_pkg::I2C_TXDATA) begin
            tx_q <= wb.dat_w[7:0];
        end
        if (go) begin
            stop_q <= wb.dat_w[tagger_link_pkg::CMD_STOP];
            rd_q   <= wb.dat_w[tagger_link_pkg::CMD_READ];
            nack_q <= wb.dat_w[tagger_link_pkg::CMD_NACK];
            sh_q   <= tx_q;
        end else if (tick && state_q == tagger_link_pkg::BIT_HIGH) begin
            sh_q <= {sh_q[6:0], sda_i};
        end
        if (tick && state_q == tagger_link_pkg::ACK_HIGH && rd_q) begin
            rx_q <= sh_q;
        end
    end

    always_ff @(posedge okClk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q      <= 1'b0;
            prescale_q <= 16'(PRESCALE_RESET);
            state_q    <= tagger_link_pkg::IDLE;
            div_q      <= '0;
            step_q     <= '0;
            bit_q      <= '0;
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
            rx_nack_q  <= 1'b0;
        end else begin
            ack_q <= wb.cyc && wb.stb && !ack_q;
            if (wr && wb.adr[7:0] == tagger_link_pkg::I2C_PRESCALE) begin
                prescale_q <= wb.dat_w[15:0];
            end
            if (!busy || tick) begin
                div_q <= '0;
            end else if (!stretch) begin
                div_q <= div_q + 1'b1;
            end
            if (go) begin
                step_q  <= '0;
                state_q <= wb.dat_w[tagger_link_pkg::CMD_START] ?
                           tagger_link_pkg::START : tagger_link_pkg::BIT_LOW;
            end else if (busy && tick) begin
                step_q <= step_q + 1'b1;
                case (state_q)
                    tagger_link_pkg::START: begin
                        // Release both lines, then SDA falls while SCL is high
                        case (step_q)
                            2'd0: sda_q <= 1'b1;
                            2'd1: scl_q <= 1'b1;
                            2'd2: sda_q <= 1'b0;
                            default: begin
                                scl_q   <= 1'b0;
                                step_q  <= '0;
                                state_q <= tagger_link_pkg::BIT_LOW;
                            end
                        endcase
                    end
                    tagger_link_pkg::BIT_LOW: begin
                        if (step_q == 2'd0) begin
                            sda_q <= rd_q || sh_q[7];
                        end else begin
                            scl_q   <= 1'b1;
                            step_q  <= '0;
                            state_q <= tagger_link_pkg::BIT_HIGH;
                        end
                    end
                    tagger_link_pkg::BIT_HIGH: begin
                        scl_q   <= 1'b0;
                        bit_q   <= bit_q + 1'b1;
                        step_q  <= '0;
                        state_q <= (bit_q == 3'd7) ?
                                   tagger_link_pkg::ACK_LOW : tagger_link_pkg::BIT_LOW;
                    end
                    tagger_link_pkg::ACK_LOW: begin
                        if (step_q == 2'd0) begin
                            sda_q <= rd_q ? nack_q : 1'b1;
                        end else begin
                            scl_q   <= 1'b1;
                            step_q  <= '0;
                            state_q <= tagger_link_pkg::ACK_HIGH;
                        end
                    end
                    tagger_link_pkg::ACK_HIGH: begin
                        if (!rd_q) begin
                            rx_nack_q <= sda_i;
                        end
                        scl_q   <= 1'b0;
                        step_q  <= '0;
                        state_q <= stop_q ? tagger_link_pkg::STOP : tagger_link_pkg::DONE;
                    end
                    tagger_link_pkg::STOP: begin
                        case (step_q)
                            2'd0: sda_q <= 1'b0;
                            2'd1: scl_q <= 1'b1;
                            default: begin
                                sda_q   <= 1'b1;
                                step_q  <= '0;
                                state_q <= tagger_link_pkg::DONE;
                            end
                        endcase
                    end
                    default: begin
                        // SCL stays low between bytes without stop
                        sda_q   <= 1'b1;
                        step_q  <= '0;
                        state_q <= tagger_link_pkg::IDLE;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hw/link_ctrl_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 10G link control and status
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module link_ctrl_regs (
    input  wire  okClk,
    input  wire  rst_n_i,
    wb_if.slave  wb,
    input  wire  link_up_i,
    output logic link_tx_en_o
);

    logic [31:0] scratch_q;
    logic [1:0]  up_sync_q;
    logic        ack_q;
    logic        wr;

    assign wr     = wb.cyc && wb.stb && wb.we && !ack_q;
    assign wb.ack = ack_q;

    always_ff @(posedge okClk) begin
        if (wr && wb.adr[7:0] == tagger_link_pkg::LINK_SCRATCH) begin
            scratch_q <= wb.dat_w;
        end
    end

    // ID and status writes are acked and dropped
    always_ff @(posedge okClk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q        <= 1'b0;
            link_tx_en_o <= 1'b0;
            up_sync_q    <= '0;
        end else begin
            ack_q     <= wb.cyc && wb.stb && !ack_q;
            up_sync_q <= {up_sync_q[0], link_up_i};
            if (wr && wb.adr[7:0] == tagger_link_pkg::LINK_CONTROL) begin
                link_tx_en_o <= wb.dat_w[0];
            end
        end
    end

    always_comb begin
        case (wb.adr[7:0])
            tagger_link_pkg::LINK_ID:      wb.dat_r = tagger_link_pkg::LINK_ID_VALUE;
            tagger_link_pkg::LINK_SCRATCH: wb.dat_r = scratch_q;
            tagger_link_pkg::LINK_CONTROL: wb.dat_r = {31'b0, link_tx_en_o};
            tagger_link_pkg::LINK_STATUS:  wb.dat_r = {31'b0, up_sync_q[1]};
            default:                       wb.dat_r = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/tagger_link_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tagger link management top
// Host bridge, decoder, PLL I2C and link registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tagger_link_top #(
    parameter int ACK_TIMEOUT    = 64,
    parameter int PRESCALE_RESET = 4
) (
    input  wire                                okClk,
    input  wire                                rst_n_i,
    // Host command and response streams
    input  wire                                cmd_valid_i,
    output logic                               cmd_ready_o,
    input  tagger_link_pkg::host_op_e          cmd_op_i,
    input  wire [tagger_link_pkg::ADDR_W-1:0]  cmd_addr_i,
    input  wire [tagger_link_pkg::DATA_W-1:0]  cmd_data_i,
    output logic                               rsp_valid_o,
    input  wire                                rsp_ready_i,
    output logic [tagger_link_pkg::DATA_W-1:0] rsp_data_o,
    output logic                               rsp_err_o,
    // PLL I2C pads, open drain
    output logic                               scl_o,
    output logic                               scl_oen_o,
    input  wire                                scl_i,
    output logic                               sda_o,
    output logic                               sda_oen_o,
    input  wire                                sda_i,
    input  wire                                link_up_i,
    output logic                               link_tx_en_o
);

    wb_if wb_m ();
    wb_if wb_i2c ();
    wb_if wb_link ();

    host_wb_bridge #(
        .ACK_TIMEOUT(ACK_TIMEOUT)
    ) i_bridge (
        .okClk      (okClk),
        .rst_n_i    (rst_n_i),
        .cmd_valid_i(cmd_valid_i),
        .cmd_ready_o(cmd_ready_o),
        .cmd_op_i   (cmd_op_i),
        .cmd_addr_i (cmd_addr_i),
        .cmd_data_i (cmd_data_i),
        .rsp_valid_o(rsp_valid_o),
        .rsp_ready_i(rsp_ready_i),
        .rsp_data_o (rsp_data_o),
        .rsp_err_o  (rsp_err_o),
        .wb         (wb_m)
    );

    wb_addr_decoder i_decoder (
        .okClk  (okClk),
        .rst_n_i(rst_n_i),
        .m      (wb_m),
        .s_i2c  (wb_i2c),
        .s_link (wb_link)
    );

    i2c_byte_master #(
        .PRESCALE_RESET(PRESCALE_RESET)
    ) i_pll_i2c (
        .okClk    (okClk),
        .rst_n_i  (rst_n_i),
        .wb       (wb_i2c),
        .scl_o    (scl_o),
        .scl_oen_o(scl_oen_o),
        .scl_i    (scl_i),
        .sda_o    (sda_o),
        .sda_oen_o(sda_oen_o),
        .sda_i    (sda_i)
    );

    link_ctrl_regs i_link (
        .okClk       (okClk),
        .rst_n_i     (rst_n_i),
        .wb          (wb_link),
        .link_up_i   (link_up_i),
        .link_tx_en_o(link_tx_en_o)
    );

endmodule

`default_nettype wire

/* sim/i2c_target_model.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PLL I2C target model
// Acks one address, returns a fixed byte on read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module i2c_target_model #(
    parameter logic [6:0] DEV_ADDR  = 7'h70,
    parameter logic [7:0] READ_BYTE = 8'hA5
) (
    input  wire  scl_i,
    input  wire  sda_i,
    output logic sda_low_o
);

    logic       scl_prev;
    logic       sda_prev;
    logic       active;
    logic       addressed;
    logic       reading;
    logic [7:0] shift;
    int         bit_cnt;
    int         byte_cnt;

    initial begin
        scl_prev  = 1'b1;
        sda_prev  = 1'b1;
        active    = 1'b0;
        addressed = 1'b0;
        reading   = 1'b0;
        shift     = '0;
        bit_cnt   = 0;
        byte_cnt  = 0;
        sda_low_o = 1'b0;
    end

    // SDA only changes while SCL is low, except for start and stop
    always @(scl_i or sda_i) begin
        if (scl_i && scl_prev && sda_prev && !sda_i) begin
            // Start or repeated start
            active    = 1'b1;
            addressed = 1'b0;
            bit_cnt   = 0;
            byte_cnt  = 0;
            sda_low_o = 1'b0;
        end else if (scl_i && scl_prev && !sda_prev && sda_i) begin
            active    = 1'b0;
            sda_low_o = 1'b0;
        end else if (active && scl_i && !scl_prev) begin
            if (bit_cnt < 8) begin
                shift = {shift[6:0], sda_i};
            end else if (reading && byte_cnt != 0 && sda_i) begin
                // Host NACK ends the read
                addressed = 1'b0;
            end
            bit_cnt = bit_cnt + 1;
        end else if (active && !scl_i && scl_prev) begin
            if (bit_cnt == 8) begin
                if (byte_cnt == 0) begin
                    addressed = (shift[7:1] == DEV_ADDR);
                    reading   = shift[0];
                end
                // Ack address and written bytes, release for the host ack
                sda_low_o = addressed && !(reading && byte_cnt != 0);
            end else if (bit_cnt == 9) begin
                bit_cnt   = 0;
                byte_cnt  = byte_cnt + 1;
                sda_low_o = addressed && reading && !READ_BYTE[7];
            end else if (bit_cnt != 0) begin
                sda_low_o = addressed && reading && byte_cnt != 0 && !READ_BYTE[7 - bit_cnt];
            end
        end
        scl_prev = scl_i;
        sda_prev = sda_i;
    end

endmodule

`default_nettype wire

/* sim/tagger_link_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tagger link testbench
// Table-driven host accesses with a PLL I2C target
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tagger_link_tb;

    localparam int          CLK_PERIOD       = 10;
    localparam int          CYCLES_PER_ENTRY = 2000;
    localparam int          PRESCALE         = 4;
    localparam logic [31:0] ALL              = 32'hFFFF_FFFF;

    typedef struct {
        tagger_link_pkg::host_op_e op;
        logic [23:0]               addr;
        logic [31:0]               data;
        logic [31:0]               exp_data;
        logic [31:0]               mask;
        logic                      exp_err;
        int                        stall;
        logic                      poll;
    } entry_t;

    logic                      okClk;
    logic                      rst_n_i;
    logic                      cmd_valid_i;
    logic                      cmd_ready_o;
    tagger_link_pkg::host_op_e cmd_op_i;
    logic [23:0]               cmd_addr_i;
    logic [31:0]               cmd_data_i;
    logic                      rsp_valid_o;
    logic                      rsp_ready_i;
    logic [31:0]               rsp_data_o;
    logic                      rsp_err_o;
    logic                      scl_o;
    logic                      scl_oen_o;
    logic                      sda_o;
    logic                      sda_oen_o;
    logic                      link_up_i;
    logic                      link_tx_en_o;
    logic                      target_sda_low;
    wire                       scl;
    wire                       sda;

    entry_t table_q[$];
    logic   table_ready;
    int     seed;
    int     checks;
    int     errors;

    // Open-drain lines with pull-ups
    assign scl = !(!scl_oen_o && !scl_o);
    assign sda = !((!sda_oen_o && !sda_o) || target_sda_low);

    tagger_link_top #(
        .ACK_TIMEOUT   (64),
        .PRESCALE_RESET(PRESCALE)
    ) i_dut (
        .okClk       (okClk),
        .rst_n_i     (rst_n_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_ready_o (cmd_ready_o),
        .cmd_op_i    (cmd_op_i),
        .cmd_addr_i  (cmd_addr_i),
        .cmd_data_i  (cmd_data_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_data_o  (rsp_data_o),
        .rsp_err_o   (rsp_err_o),
        .scl_o       (scl_o),
        .scl_oen_o   (scl_oen_o),
        .scl_i       (scl),
        .sda_o       (sda_o),
        .sda_oen_o   (sda_oen_o),
        .sda_i       (sda),
        .link_up_i   (link_up_i),
        .link_tx_en_o(link_tx_en_o)
    );

    i2c_target_model i_pll_target (
        .scl_i    (scl),
        .sda_i    (sda),
        .sda_low_o(target_sda_low)
    );

    initial begin
        okClk = 1'b0;
        forever #(CLK_PERIOD / 2) okClk = ~okClk;
    end

    // Link partner comes up one cycle after the transmitter is enabled
    initial begin
        logic tx_seen;
        link_up_i = 1'b0;
        forever begin
            @(negedge okClk);
            tx_seen = link_tx_en_o;
            @(posedge okClk);
            link_up_i <= tx_seen;
        end
    end

    initial begin
        wait (table_ready);
        #(table_q.size() * CYCLES_PER_ENTRY * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles",
                 table_q.size() * CYCLES_PER_ENTRY);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("Checks failed");
        $finish;
    end

    // An enabled pad may only pull its line low
    always @(negedge okClk) begin
        if (!scl_oen_o) begin
            check_bit("scl_o while enabled", scl_o, 1'b0);
        end
        if (!sda_oen_o) begin
            check_bit("sda_o while enabled", sda_o, 1'b0);
        end
    end

    function automatic logic [23:0] link_reg(input logic [7:0] off);
        return {tagger_link_pkg::PAGE_LINK, off};
    endfunction

    function automatic logic [23:0] i2c_reg(input logic [7:0] off);
        return {tagger_link_pkg::PAGE_I2C, off};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        check_value(what, {31'b0, got}, {31'b0, exp});
    endtask

    task automatic add_entry(input tagger_link_pkg::host_op_e op, input logic [23:0] addr,
                             input logic [31:0] data, input logic [31:0] exp_data,
                             input logic [31:0] mask, input logic exp_err, input logic poll);
        int stall;
        stall = $random(seed) & 7;
        table_q.push_back(entry_t'{op: op, addr: addr, data: data, exp_data: exp_data,
                                   mask: mask, exp_err: exp_err, stall: stall, poll: poll});
    endtask

    // Writes always answer with zero data
    task automatic write_entry(input logic [23:0] addr, input logic [31:0] data,
                               input logic exp_err);
        add_entry(tagger_link_pkg::OP_WRITE, addr, data, 32'h0, ALL, exp_err, 1'b0);
    endtask

    task automatic read_entry(input logic [23:0] addr, input logic [31:0] exp_data,
                              input logic [31:0] mask, input logic exp_err, input logic poll);
        add_entry(tagger_link_pkg::OP_READ, addr, 32'h0, exp_data, mask, exp_err, poll);
    endtask

    task automatic build_table();
        read_entry(link_reg(tagger_link_pkg::LINK_ID), tagger_link_pkg::LINK_ID_VALUE,
                   ALL, 1'b0, 1'b0);
        write_entry(link_reg(tagger_link_pkg::LINK_ID), 32'hFFFF_FFFF, 1'b0);
        read_entry(link_reg(tagger_link_pkg::LINK_ID), tagger_link_pkg::LINK_ID_VALUE,
                   ALL, 1'b0, 1'b0);
        write_entry(link_reg(tagger_link_pkg::LINK_SCRATCH), 32'h5A5A_1234, 1'b0);
        read_entry(link_reg(tagger_link_pkg::LINK_SCRATCH), 32'h5A5A_1234, ALL, 1'b0, 1'b0);
        read_entry(link_reg(tagger_link_pkg::LINK_STATUS), 32'h0, ALL, 1'b0, 1'b0);
        write_entry(link_reg(tagger_link_pkg::LINK_CONTROL), 32'h1, 1'b0);
        read_entry(link_reg(tagger_link_pkg::LINK_CONTROL), 32'h1, ALL, 1'b0, 1'b0);
        read_entry(link_reg(tagger_link_pkg::LINK_STATUS), 32'h1, ALL, 1'b0, 1'b0);
        // Unmapped pages and the always-ack sink
        read_entry(24'h12_3456, 32'h0, ALL, 1'b1, 1'b0);
        write_entry(24'h80_1600, 32'h1234_5678, 1'b1);
        write_entry({tagger_link_pkg::PAGE_ACK, 8'h10}, 32'hDEAD_BEEF, 1'b0);
        read_entry({tagger_link_pkg::PAGE_ACK, 8'h10}, 32'h0, ALL, 1'b0, 1'b0);
        // PLL I2C with an acked address, an unknown address and one read byte
        read_entry(i2c_reg(tagger_link_pkg::I2C_PRESCALE), PRESCALE, ALL, 1'b0, 1'b0);
        write_entry(i2c_reg(tagger_link_pkg::I2C_TXDATA), 32'hE0, 1'b0);
        write_entry(i2c_reg(tagger_link_pkg::I2C_CMD), 32'h1 << tagger_link_pkg::CMD_START, 1'b0);
        read_entry(i2c_reg(tagger_link_pkg::I2C_STATUS), 32'h0, 32'h3, 1'b0, 1'b1);
        write_entry(i2c_reg(tagger_link_pkg::I2C_TXDATA), 32'hE2, 1'b0);
        write_entry(i2c_reg(tagger_link_pkg::I2C_CMD), 32'h1 << tagger_link_pkg::CMD_START, 1'b0);
        read_entry(i2c_reg(tagger_link_pkg::I2C_STATUS), 32'h2, 32'h3, 1'b0, 1'b1);
        write_entry(i2c_reg(tagger_link_pkg::I2C_TXDATA), 32'hE1, 1'b0);
        write_entry(i2c_reg(tagger_link_pkg::I2C_CMD), 32'h1 << tagger_link_pkg::CMD_START, 1'b0);
        read_entry(i2c_reg(tagger_link_pkg::I2C_STATUS), 32'h0, 32'h3, 1'b0, 1'b1);
        write_entry(i2c_reg(tagger_link_pkg::I2C_CMD),
                    (32'h1 << tagger_link_pkg::CMD_READ) | (32'h1 << tagger_link_pkg::CMD_NACK) |
                    (32'h1 << tagger_link_pkg::CMD_STOP), 1'b0);
        read_entry(i2c_reg(tagger_link_pkg::I2C_STATUS), 32'hA500, 32'hFF03, 1'b0, 1'b1);
    endtask

    task automatic run_access(input entry_t e, output logic [31:0] data, output logic err);
        @(posedge okClk);
        cmd_valid_i <= 1'b1;
        cmd_op_i    <= e.op;
        cmd_addr_i  <= e.addr;
        cmd_data_i  <= e.data;
        @(negedge okClk);
        while (!cmd_ready_o) @(negedge okClk);
        @(posedge okClk);
        cmd_valid_i <= 1'b0;
        @(negedge okClk);
        while (!rsp_valid_o) @(negedge okClk);
        data = rsp_data_o;
        err  = rsp_err_o;
        // Response has to hold while the host stalls
        repeat (e.stall) begin
            @(negedge okClk);
            check_bit("rsp_valid_o under stall", rsp_valid_o, 1'b1);
            check_value("rsp_data_o under stall", rsp_data_o, data);
            check_bit("rsp_err_o under stall", rsp_err_o, err);
            check_bit("cmd_ready_o under stall", cmd_ready_o, 1'b0);
        end
        @(posedge okClk);
        rsp_ready_i <= 1'b1;
        @(posedge okClk);
        rsp_ready_i <= 1'b0;
    endtask

    initial begin
        logic [31:0] got_data;
        logic        got_err;
        table_ready = 1'b0;
        seed        = 87334;
        checks      = 0;
        errors      = 0;
        rst_n_i     = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_op_i    = tagger_link_pkg::OP_READ;
        cmd_addr_i  = '0;
        cmd_data_i  = '0;
        rsp_ready_i = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge okClk);
        rst_n_i <= 1'b1;
        @(negedge okClk);
        check_bit("cmd_ready_o after reset", cmd_ready_o, 1'b1);
        check_bit("rsp_valid_o after reset", rsp_valid_o, 1'b0);
        check_bit("link_tx_en_o after reset", link_tx_en_o, 1'b0);
        check_bit("scl_oen_o after reset", scl_oen_o, 1'b1);
        check_bit("sda_oen_o after reset", sda_oen_o, 1'b1);
        foreach (table_q[i]) begin
            // Poll entries repeat while the busy bit is set
            do begin
                run_access(table_q[i], got_data, got_err);
            end while (table_q[i].poll && !got_err && got_data[0]);
            check_value($sformatf("entry %0d rsp_data_o", i), got_data & table_q[i].mask,
                        table_q[i].exp_data & table_q[i].mask);
            check_bit($sformatf("entry %0d rsp_err_o", i), got_err, table_q[i].exp_err);
        end
        @(negedge okClk);
        check_bit("link_tx_en_o at end", link_tx_en_o, 1'b1);
        check_bit("scl_oen_o after stop", scl_oen_o, 1'b1);
        check_bit("sda_oen_o after stop", sda_oen_o, 1'b1);
        check_bit("SDA line after stop", sda, 1'b1);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tagger_link.f */
hw/tagger_link_pkg.sv
hw/wb_if.sv
hw/host_wb_bridge.sv
hw/wb_addr_decoder.sv
hw/i2c_byte_master.sv
hw/link_ctrl_regs.sv
hw/tagger_link_top.sv
sim/i2c_target_model.sv
sim/tagger_link_tb.sv

/* Makefile */
TOP := tagger_link_tb

.PHONY: all build lint clean

all: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "All checks passed"

build:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f tagger_link.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ns \
		-f tagger_link.f --top-module $(TOP)

clean:
	rm -rf obj_dir
